// ==== hw/lookup_pkg.sv ====
// shared widths, header field layout and state codes for the match stage
// imported by the control parser, the CAM, the action RAM, the sequencer and the top

package lookup_pkg;

    // control stream
    localparam int ctrl_data_w = 512;
    localparam int ctrl_user_w = 128;
    localparam int ctrl_keep_w = 64;

    // lookup path
    localparam int key_w      = 101;
    localparam int vlan_nib_w = 4;
    localparam int cam_w      = vlan_nib_w + key_w;
    localparam int act_w      = 625;
    localparam int phv_w      = 868;

    // table geometry
    localparam int tbl_depth   = 16;
    localparam int tbl_addr_w  = 4;
    localparam int tbl_index_w = 8;

    // header fields and codes
    localparam int          vlan_nib_lsb   = 133;
    localparam int          stage_id_w     = 5;
    localparam int          lookup_id_w    = 3;
    localparam logic [15:0] ctrl_flag_code = 16'hf2f1;
    localparam logic [3:0]  kind_cam       = 4'd0;
    localparam int          act_hi_w       = 512;
    localparam int          act_lo_w       = 113;

    localparam logic [act_w-1:0] default_action = act_w'('h3f);

    // control parser states
    localparam logic [2:0] cfg_idle   = 3'd0;
    localparam logic [2:0] cfg_cam    = 3'd1;
    localparam logic [2:0] cfg_act_hi = 3'd2;
    localparam logic [2:0] cfg_act_lo = 3'd3;
    localparam logic [2:0] cfg_fwd    = 3'd4;

    // lookup sequencer states
    localparam logic [1:0] lk_idle     = 2'd0;
    localparam logic [1:0] lk_wait_cam = 2'd1;
    localparam logic [1:0] lk_wait_ram = 2'd2;
    localparam logic [1:0] lk_send     = 2'd3;

    // one raw control beat, seen either as a header or as 64 wire-order bytes
    typedef union packed {
        struct packed {
            logic [119:0]             rsvd_hi;
            logic [tbl_index_w-1:0]   index;
            logic [3:0]               rsvd_kind;
            logic [3:0]               kind;
            logic [stage_id_w-1:0]    stage;
            logic [lookup_id_w-1:0]   lookup;
            logic [31:0]              rsvd_mid;
            logic [15:0]              flag;
            logic [319:0]             rsvd_lo;
        } hdr;
        logic [ctrl_keep_w-1:0][7:0] bytes;
    } cfg_beat_u;

endpackage

// ==== hw/ctrl_cfg_parser.sv ====
// control stream parser for the match stage
// consumes configuration packets addressed to this stage and turns them into
// CAM and action RAM writes, every other packet leaves registered one cycle later

`timescale 1ns/1ns

module ctrl_cfg_parser #(
    parameter logic [lookup_pkg::stage_id_w-1:0]  stage_id  = '0,
    parameter logic [lookup_pkg::lookup_id_w-1:0] lookup_id = '0
) (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [lookup_pkg::ctrl_data_w-1:0] c_s_axis_tdata,
    input  logic [lookup_pkg::ctrl_user_w-1:0] c_s_axis_tuser,
    input  logic [lookup_pkg::ctrl_keep_w-1:0] c_s_axis_tkeep,
    input  logic                               c_s_axis_tvalid,
    input  logic                               c_s_axis_tlast,

    output logic [lookup_pkg::ctrl_data_w-1:0] c_m_axis_tdata,
    output logic [lookup_pkg::ctrl_user_w-1:0] c_m_axis_tuser,
    output logic [lookup_pkg::ctrl_keep_w-1:0] c_m_axis_tkeep,
    output logic                               c_m_axis_tvalid,
    output logic                               c_m_axis_tlast,

    output logic                               cam_we,
    output logic [lookup_pkg::tbl_addr_w-1:0]  cam_addr,
    output logic [lookup_pkg::cam_w-1:0]       cam_din,
    output logic                               act_we,
    output logic [lookup_pkg::tbl_addr_w-1:0]  act_addr,
    output logic [lookup_pkg::act_w-1:0]       act_din
);
    import lookup_pkg::*;

    logic [2:0]             state;
    logic [tbl_addr_w-1:0]  wr_ptr;
    logic [act_hi_w-1:0]    act_hi;
    cfg_beat_u              beat;
    logic [ctrl_data_w-1:0] payload;
    logic                   ours;
    logic                   fwd_beat;

    assign beat = c_s_axis_tdata;

    // wire order is little endian, entries are packed big endian
    always_comb begin
        for (int i = 0; i < ctrl_keep_w; i++) begin
            payload[8*(ctrl_keep_w-1-i) +: 8] = beat.bytes[i];
        end
    end

    assign ours = (beat.hdr.flag == ctrl_flag_code) &&
                  (beat.hdr.stage == stage_id) &&
                  (beat.hdr.lookup == lookup_id);

    // foreign header in idle, or any beat of a packet already judged foreign
    assign fwd_beat = c_s_axis_tvalid &&
                      (((state == cfg_idle) && !ours) || (state == cfg_fwd));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= cfg_idle;
            wr_ptr          <= '0;
            cam_we          <= 1'b0;
            act_we          <= 1'b0;
            c_m_axis_tvalid <= 1'b0;
            c_m_axis_tlast  <= 1'b0;
        end else begin
            cam_we          <= 1'b0;
            act_we          <= 1'b0;
            c_m_axis_tvalid <= fwd_beat;
            c_m_axis_tlast  <= fwd_beat && c_s_axis_tlast;

            if (c_s_axis_tvalid) begin
                case (state)
                    cfg_idle: begin
                        if (ours) begin
                            wr_ptr <= beat.hdr.index[tbl_addr_w-1:0];
                            // a header-only packet carries nothing to write
                            if (!c_s_axis_tlast) begin
                                state <= (beat.hdr.kind == kind_cam) ? cfg_cam : cfg_act_hi;
                            end
                        end else if (!c_s_axis_tlast) begin
                            state <= cfg_fwd;
                        end
                    end
                    cfg_cam: begin
                        cam_we <= 1'b1;
                        wr_ptr <= wr_ptr + 1'b1;
                        if (c_s_axis_tlast) begin
                            state <= cfg_idle;
                        end
                    end
                    cfg_act_hi: begin
                        // a lone upper half at the end is dropped
                        state <= c_s_axis_tlast ? cfg_idle : cfg_act_lo;
                    end
                    cfg_act_lo: begin
                        act_we <= 1'b1;
                        wr_ptr <= wr_ptr + 1'b1;
                        state  <= c_s_axis_tlast ? cfg_idle : cfg_act_hi;
                    end
                    cfg_fwd: begin
                        if (c_s_axis_tlast) begin
                            state <= cfg_idle;
                        end
                    end
                    default: state <= cfg_idle;
                endcase
            end
        end
    end

    // forwarded payload and write data
    always_ff @(posedge clk) begin
        if (fwd_beat) begin
            c_m_axis_tdata <= c_s_axis_tdata;
            c_m_axis_tuser <= c_s_axis_tuser;
            c_m_axis_tkeep <= c_s_axis_tkeep;
        end
        if (c_s_axis_tvalid && (state == cfg_cam)) begin
            cam_addr <= wr_ptr;
            cam_din  <= payload[ctrl_data_w-1 -: cam_w];
        end
        if (c_s_axis_tvalid && (state == cfg_act_hi)) begin
            act_hi <= payload[ctrl_data_w-1 -: act_hi_w];
        end
        if (c_s_axis_tvalid && (state == cfg_act_lo)) begin
            act_addr <= wr_ptr;
            act_din  <= {act_hi, payload[ctrl_data_w-1 -: act_lo_w]};
        end
    end

endmodule

// ==== hw/ternary_cam.sv ====
// 16-entry ternary CAM, compare every cycle with a registered result
// a set bit in cmp_mask is don't-care; lowest matching index is reported

`timescale 1ns/1ns

module ternary_cam (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              we,
    input  logic [lookup_pkg::tbl_addr_w-1:0] wr_addr,
    input  logic [lookup_pkg::cam_w-1:0]      din,
    input  logic [lookup_pkg::cam_w-1:0]      cmp_din,
    input  logic [lookup_pkg::cam_w-1:0]      cmp_mask,
    output logic                              match,
    output logic [lookup_pkg::tbl_addr_w-1:0] match_addr
);
    import lookup_pkg::*;

    logic [cam_w-1:0]      entry [tbl_depth];
    logic [tbl_depth-1:0]  entry_vld;
    logic [tbl_depth-1:0]  hit;
    logic [tbl_addr_w-1:0] hit_addr;

    always_ff @(posedge clk) begin
        if (we) begin
            entry[wr_addr] <= din;
        end
    end

    // table starts empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld <= '0;
        end else if (we) begin
            entry_vld[wr_addr] <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < tbl_depth; i++) begin
            hit[i] = entry_vld[i] && (((entry[i] ^ cmp_din) & ~cmp_mask) == '0);
        end
    end

    // scan from the top so the lowest hit is the one left standing
    always_comb begin
        hit_addr = '0;
        for (int i = tbl_depth - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_addr = tbl_addr_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match      <= 1'b0;
            match_addr <= '0;
        end else begin
            match      <= |hit;
            match_addr <= hit_addr;
        end
    end

endmodule

// ==== hw/action_ram.sv ====
// action table, 16 x 625 bits
// written by the control parser, read at the CAM match address one cycle later

`timescale 1ns/1ns

module action_ram (
    input  logic                              clk,
    input  logic                              we,
    input  logic [lookup_pkg::tbl_addr_w-1:0] wr_addr,
    input  logic [lookup_pkg::act_w-1:0]      din,
    input  logic [lookup_pkg::tbl_addr_w-1:0] rd_addr,
    output logic [lookup_pkg::act_w-1:0]      rd_data
);
    import lookup_pkg::*;

    logic [act_w-1:0] mem [tbl_depth];

    // simple dual port, read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== hw/lookup_fsm.sv ====
// lookup sequencer
// holds the PHV of an accepted key until its action is known, then sends both
// miss answers after two cycles with the default action, hit after four

`timescale 1ns/1ns

module lookup_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  logic [lookup_pkg::phv_w-1:0] phv_in,
    input  logic                         match,
    input  logic [lookup_pkg::act_w-1:0] act_rd,
    output logic [lookup_pkg::act_w-1:0] action,
    output logic                         action_valid,
    output logic [lookup_pkg::phv_w-1:0] phv_out
);
    import lookup_pkg::*;

    logic [1:0]       state;
    logic [phv_w-1:0] phv_reg;
    logic             key_take;

    // new keys are only looked at while idle
    assign key_take = (state == lk_idle) && key_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= lk_idle;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                lk_idle: begin
                    if (key_valid) begin
                        state <= lk_wait_cam;
                    end
                end
                lk_wait_cam: begin
                    if (match) begin
                        state <= lk_wait_ram;
                    end else begin
                        action_valid <= 1'b1;
                        state        <= lk_idle;
                    end
                end
                // RAM read of the match address lands here
                lk_wait_ram: state <= lk_send;
                lk_send: begin
                    action_valid <= 1'b1;
                    state        <= lk_idle;
                end
                default: state <= lk_idle;
            endcase
        end
    end

    // the CAM compares every cycle, so the read for this key is only valid in wait_ram
    always_ff @(posedge clk) begin
        if (key_take) begin
            phv_reg <= phv_in;
        end
        if ((state == lk_wait_cam) && !match) begin
            action  <= default_action;
            phv_out <= phv_reg;
        end
        if (state == lk_wait_ram) begin
            action  <= act_rd;
            phv_out <= phv_reg;
        end
    end

endmodule

// ==== hw/lookup_engine.sv ====
// match stage top: control parser, ternary CAM, action RAM and sequencer
// stage_id and lookup_id select which configuration packets this instance takes

`timescale 1ns/1ns

module lookup_engine #(
    parameter logic [lookup_pkg::stage_id_w-1:0]  stage_id  = '0,
    parameter logic [lookup_pkg::lookup_id_w-1:0] lookup_id = '0
) (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [lookup_pkg::key_w-1:0]       extract_key,
    input  logic [lookup_pkg::key_w-1:0]       extract_mask,
    input  logic                               key_valid,
    input  logic [lookup_pkg::phv_w-1:0]       phv_in,

    output logic [lookup_pkg::act_w-1:0]       action,
    output logic                               action_valid,
    output logic [lookup_pkg::phv_w-1:0]       phv_out,

    input  logic [lookup_pkg::ctrl_data_w-1:0] c_s_axis_tdata,
    input  logic [lookup_pkg::ctrl_user_w-1:0] c_s_axis_tuser,
    input  logic [lookup_pkg::ctrl_keep_w-1:0] c_s_axis_tkeep,
    input  logic                               c_s_axis_tvalid,
    input  logic                               c_s_axis_tlast,

    output logic [lookup_pkg::ctrl_data_w-1:0] c_m_axis_tdata,
    output logic [lookup_pkg::ctrl_user_w-1:0] c_m_axis_tuser,
    output logic [lookup_pkg::ctrl_keep_w-1:0] c_m_axis_tkeep,
    output logic                               c_m_axis_tvalid,
    output logic                               c_m_axis_tlast
);
    import lookup_pkg::*;

    logic                  cam_we;
    logic [tbl_addr_w-1:0] cam_addr;
    logic [cam_w-1:0]      cam_din;
    logic                  act_we;
    logic [tbl_addr_w-1:0] act_addr;
    logic [act_w-1:0]      act_din;
    logic                  match;
    logic [tbl_addr_w-1:0] match_addr;
    logic [act_w-1:0]      act_rd;
    logic [vlan_nib_w-1:0] vlan_nib;

    assign vlan_nib = phv_in[vlan_nib_lsb +: vlan_nib_w];

    ctrl_cfg_parser #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) i_parser (
        .clk             (clk),
        .rst_n           (rst_n),
        .c_s_axis_tdata  (c_s_axis_tdata),
        .c_s_axis_tuser  (c_s_axis_tuser),
        .c_s_axis_tkeep  (c_s_axis_tkeep),
        .c_s_axis_tvalid (c_s_axis_tvalid),
        .c_s_axis_tlast  (c_s_axis_tlast),
        .c_m_axis_tdata  (c_m_axis_tdata),
        .c_m_axis_tuser  (c_m_axis_tuser),
        .c_m_axis_tkeep  (c_m_axis_tkeep),
        .c_m_axis_tvalid (c_m_axis_tvalid),
        .c_m_axis_tlast  (c_m_axis_tlast),
        .cam_we          (cam_we),
        .cam_addr        (cam_addr),
        .cam_din         (cam_din),
        .act_we          (act_we),
        .act_addr        (act_addr),
        .act_din         (act_din)
    );

    // the VLAN nibble is always compared exactly
    ternary_cam i_cam (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (cam_we),
        .wr_addr    (cam_addr),
        .din        (cam_din),
        .cmp_din    ({vlan_nib, extract_key}),
        .cmp_mask   ({{vlan_nib_w{1'b0}}, extract_mask}),
        .match      (match),
        .match_addr (match_addr)
    );

    action_ram i_ram (
        .clk     (clk),
        .we      (act_we),
        .wr_addr (act_addr),
        .din     (act_din),
        .rd_addr (match_addr),
        .rd_data (act_rd)
    );

    lookup_fsm i_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .match        (match),
        .act_rd       (act_rd),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

// ==== dv/lookup_engine_chk.sv ====
// protocol assertions for the match stage outputs
// bound into every lookup_engine instance, fail_cnt is read back by the testbench

`timescale 1ns/1ns

module lookup_engine_chk (
    input logic       clk,
    input logic       rst_n,
    input logic       key_valid,
    input logic       action_valid,
    input logic       c_m_axis_tvalid,
    input logic       c_m_axis_tlast,
    input logic [1:0] fsm_state
);
    import lookup_pkg::*;

    int fail_cnt = 0;

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        action_valid |=> !action_valid)
        else begin
            fail_cnt++;
            $error("action_valid high in two consecutive cycles");
        end

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        c_m_axis_tlast |-> c_m_axis_tvalid)
        else begin
            fail_cnt++;
            $error("c_m_axis_tlast without c_m_axis_tvalid");
        end

    // miss answers after 2 cycles, hit after 4
    a_key_answer: assert property (@(posedge clk) disable iff (!rst_n)
        (key_valid && (fsm_state == lk_idle)) |-> ##[2:4] action_valid)
        else begin
            fail_cnt++;
            $error("accepted key got no action_valid within 2 to 4 cycles");
        end

endmodule

bind lookup_engine lookup_engine_chk i_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .key_valid       (key_valid),
    .action_valid    (action_valid),
    .c_m_axis_tvalid (c_m_axis_tvalid),
    .c_m_axis_tlast  (c_m_axis_tlast),
    .fsm_state       (i_fsm.state)
);

// ==== dv/tb_lookup_engine.sv ====
// random testbench for the match stage top
// drives control packets and keys from an LCG, checks actions, PHVs and forwarded
// beats against a CAM/action model and a queue of expected control beats

`timescale 1ns/1ns

module tb_lookup_engine;
    import lookup_pkg::*;

    localparam logic [4:0] tb_stage  = 5'd1;
    localparam logic [2:0] tb_lookup = 3'd2;
    localparam int n_fwd     = 12;
    localparam int n_hit     = 8;
    localparam int n_miss    = 4;
    localparam int n_tern    = 6;
    localparam int n_rehit   = 10;
    // foreign packets hold at most 4 beats
    localparam int max_beats = n_fwd * 4 + (1 + 2 * 16) + (1 + 6) + (1 + 3) + (1 + 2 * 5);
    localparam int n_lk      = n_hit + n_miss + 2 * n_tern + 2 + n_rehit;
    localparam int cyc_limit = (max_beats + n_lk) * 8 + 200;

    logic                   clk;
    logic                   rst_n;
    logic [key_w-1:0]       extract_key;
    logic [key_w-1:0]       extract_mask;
    logic                   key_valid;
    logic [phv_w-1:0]       phv_in;
    logic [act_w-1:0]       action;
    logic                   action_valid;
    logic [phv_w-1:0]       phv_out;
    logic [ctrl_data_w-1:0] c_s_axis_tdata;
    logic [ctrl_user_w-1:0] c_s_axis_tuser;
    logic [ctrl_keep_w-1:0] c_s_axis_tkeep;
    logic                   c_s_axis_tvalid;
    logic                   c_s_axis_tlast;
    logic [ctrl_data_w-1:0] c_m_axis_tdata;
    logic [ctrl_user_w-1:0] c_m_axis_tuser;
    logic [ctrl_keep_w-1:0] c_m_axis_tkeep;
    logic                   c_m_axis_tvalid;
    logic                   c_m_axis_tlast;

    logic [31:0]      seed = 32'h3489_db2f;
    int               cyc = 0;
    int               n_val_err = 0;
    int               n_other_err = 0;
    logic [cam_w-1:0] cam_mdl [tbl_depth];
    logic             cam_vld [tbl_depth];
    logic [act_w-1:0] act_mdl [tbl_depth];
    logic [cam_w-1:0] new_ent [tbl_depth];
    // data, tuser, tkeep, tlast of each beat that must come out
    logic [704:0]     fwd_q [$];
    int               due_q [$];

    lookup_engine #(
        .stage_id  (tb_stage),
        .lookup_id (tb_lookup)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [1023:0] rand_wide();
        logic [1023:0] v;
        for (int i = 0; i < 32; i++) begin
            v[32*i +: 32] = lcg_next();
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [1023:0] got,
                             input logic [1023:0] exp_val);
        if (got !== exp_val) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp_val);
            n_val_err++;
        end
    endtask

    // payload is big endian, the wire carries byte 0 in the low bits
    function automatic cfg_beat_u to_wire(input logic [ctrl_data_w-1:0] p);
        cfg_beat_u b;
        for (int i = 0; i < ctrl_keep_w; i++) begin
            b.bytes[i] = p[8*(ctrl_keep_w-1-i) +: 8];
        end
        return b;
    endfunction

    function automatic cfg_beat_u make_hdr(input logic [15:0] flag, input logic [4:0] stage,
                                           input logic [2:0] lkid, input logic [3:0] kind,
                                           input logic [7:0] index);
        logic [1023:0] r;
        cfg_beat_u     b;
        r = rand_wide();
        b = r[ctrl_data_w-1:0];
        b.hdr.flag   = flag;
        b.hdr.stage  = stage;
        b.hdr.lookup = lkid;
        b.hdr.kind   = kind;
        b.hdr.index  = index;
        return b;
    endfunction

    task automatic send_beat(input logic [ctrl_data_w-1:0] data, input logic last,
                             input logic fwd);
        logic [1023:0] r;
        r = rand_wide();
        @(posedge clk);
        c_s_axis_tdata  <= data;
        c_s_axis_tuser  <= r[127:0];
        c_s_axis_tkeep  <= r[191:128];
        c_s_axis_tvalid <= 1'b1;
        c_s_axis_tlast  <= last;
        if (fwd) begin
            fwd_q.push_back({data, r[127:0], r[191:128], last});
            due_q.push_back(cyc + 2);
        end
    endtask

    // idle gap long enough for the last write to reach the tables
    task automatic end_packet();
        @(posedge clk);
        c_s_axis_tvalid <= 1'b0;
        c_s_axis_tlast  <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_foreign();
        int            nb;
        int            which;
        cfg_beat_u     h;
        logic [1023:0] r;
        nb = 1 + lcg_next() % 4;
        h = make_hdr(ctrl_flag_code, tb_stage, tb_lookup, 4'(lcg_next()), 8'(lcg_next()));
        which = lcg_next() % 3;
        if (which == 0) begin
            h.hdr.flag = h.hdr.flag ^ 16'(1 + lcg_next() % 65535);
        end else if (which == 1) begin
            h.hdr.stage = h.hdr.stage ^ 5'(1 + lcg_next() % 31);
        end else begin
            h.hdr.lookup = h.hdr.lookup ^ 3'(1 + lcg_next() % 7);
        end
        send_beat(h, nb == 1, 1'b1);
        for (int b = 1; b < nb; b++) begin
            r = rand_wide();
            // later beats that look like our header must still pass through
            if (r[1023]) begin
                h = make_hdr(ctrl_flag_code, tb_stage, tb_lookup, 4'(r[3:0]), r[15:8]);
            end else begin
                h = r[ctrl_data_w-1:0];
            end
            send_beat(h, b == nb - 1, 1'b1);
        end
    endtask

    task automatic send_actions(input logic [7:0] index, input int n);
        logic [1023:0]          r;
        logic [act_w-1:0]       a;
        logic [ctrl_data_w-1:0] p;
        send_beat(make_hdr(ctrl_flag_code, tb_stage, tb_lookup, 4'(1 + lcg_next() % 15),
                           index), 1'b0, 1'b0);
        for (int k = 0; k < n; k++) begin
            r = rand_wide();
            a = r[act_w-1:0];
            act_mdl[(index[tbl_addr_w-1:0] + k) % tbl_depth] = a;
            send_beat(to_wire(a[act_w-1 -: act_hi_w]), 1'b0, 1'b0);
            r = rand_wide();
            p = r[ctrl_data_w-1:0];
            p[ctrl_data_w-1 -: act_lo_w] = a[act_lo_w-1:0];
            send_beat(to_wire(p), k == n - 1, 1'b0);
        end
        end_packet();
    endtask

    task automatic send_cam(input logic [7:0] index, input int n);
        logic [1023:0]          r;
        logic [ctrl_data_w-1:0] p;
        int                     a;
        send_beat(make_hdr(ctrl_flag_code, tb_stage, tb_lookup, kind_cam, index), 1'b0, 1'b0);
        for (int k = 0; k < n; k++) begin
            r = rand_wide();
            p = r[ctrl_data_w-1:0];
            p[ctrl_data_w-1 -: cam_w] = new_ent[k];
            a = (index[tbl_addr_w-1:0] + k) % tbl_depth;
            cam_mdl[a] = new_ent[k];
            cam_vld[a] = 1'b1;
            send_beat(to_wire(p), k == n - 1, 1'b0);
        end
        end_packet();
    endtask

    // expected hit index, -1 on a miss
    function automatic int model_match(input logic [cam_w-1:0] cmp,
                                       input logic [key_w-1:0] mask);
        logic [cam_w-1:0] care;
        care = ~{{vlan_nib_w{1'b0}}, mask};
        for (int i = 0; i < tbl_depth; i++) begin
            if (cam_vld[i] && (((cam_mdl[i] ^ cmp) & care) == '0)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic do_lookup(input logic [key_w-1:0] key, input logic [key_w-1:0] mask,
                             input logic [vlan_nib_w-1:0] vlan);
        logic [1023:0]    r;
        logic [phv_w-1:0] phv;
        logic [act_w-1:0] exp_act;
        int               exp_idx;
        int               lat;
        logic             found;
        r = rand_wide();
        phv = r[phv_w-1:0];
        phv[vlan_nib_lsb +: vlan_nib_w] = vlan;
        exp_idx = model_match({vlan, key}, mask);
        exp_act = default_action;
        if (exp_idx >= 0) begin
            exp_act = act_mdl[exp_idx];
        end
        @(posedge clk);
        extract_key  <= key;
        extract_mask <= mask;
        phv_in       <= phv;
        key_valid    <= 1'b1;
        // key, mask and PHV only hold with the strobe
        r = rand_wide();
        @(posedge clk);
        key_valid    <= 1'b0;
        extract_key  <= r[key_w-1:0];
        extract_mask <= r[300 +: key_w];
        phv_in       <= r[1023 -: phv_w];
        lat = 0;
        found = 1'b0;
        while (!found && lat < 6) begin
            @(negedge clk);
            lat++;
            found = (action_valid === 1'b1);
        end
        if (!found) begin
            $display("no action_valid pulse within 6 cycles of a key");
            n_other_err++;
        end else begin
            check_val("action_valid latency", 1024'(lat), 1024'((exp_idx < 0) ? 2 : 4));
            check_val("action", 1024'(action), 1024'(exp_act));
            check_val("phv_out", 1024'(phv_out), 1024'(phv));
        end
    endtask

    task automatic pick_entry(output int j);
        j = lcg_next() % tbl_depth;
        while (!cam_vld[j]) begin
            j = (j + 1) % tbl_depth;
        end
    endtask

    // forwarded beats, and the run limit
    always @(negedge clk) begin
        logic [704:0] exp_beat;
        cyc++;
        if (c_m_axis_tvalid === 1'b1) begin
            if (fwd_q.size() == 0) begin
                $display("unexpected beat on the control output at cycle %0d", cyc);
                n_other_err++;
            end else begin
                exp_beat = fwd_q.pop_front();
                check_val("c_m_axis_tdata", 1024'(c_m_axis_tdata), 1024'(exp_beat[704:193]));
                check_val("c_m_axis_tuser", 1024'(c_m_axis_tuser), 1024'(exp_beat[192:65]));
                check_val("c_m_axis_tkeep", 1024'(c_m_axis_tkeep), 1024'(exp_beat[64:1]));
                check_val("c_m_axis_tlast", 1024'(c_m_axis_tlast), 1024'(exp_beat[0]));
                if (due_q[0] != cyc) begin
                    $display("forwarded beat came out at cycle %0d instead of %0d",
                             cyc, due_q[0]);
                    n_other_err++;
                end
                void'(due_q.pop_front());
            end
        end
        if (cyc > cyc_limit) begin
            $display("timeout, run still going after %0d cycles", cyc_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [1023:0]    r;
        logic [key_w-1:0] m;
        logic [key_w-1:0] diff;
        int               j;
        rst_n           = 1'b0;
        extract_key     = '0;
        extract_mask    = '0;
        key_valid       = 1'b0;
        phv_in          = '0;
        c_s_axis_tdata  = '0;
        c_s_axis_tuser  = '0;
        c_s_axis_tkeep  = '0;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        for (int i = 0; i < tbl_depth; i++) begin
            cam_vld[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // quiet outputs after reset
        repeat (5) begin
            @(negedge clk);
            check_val("action_valid", 1024'(action_valid), 1024'(1'b0));
            check_val("c_m_axis_tvalid", 1024'(c_m_axis_tvalid), 1024'(1'b0));
        end

        for (int i = 0; i < n_fwd; i++) begin
            send_foreign();
        end
        end_packet();

        // fill the whole action table, then a few CAM entries
        send_actions(8'(lcg_next()), tbl_depth);
        for (int i = 0; i < 6; i++) begin
            r = rand_wide();
            new_ent[i] = r[cam_w-1:0];
        end
        send_cam(8'(lcg_next()), 6);
        for (int i = 0; i < n_hit; i++) begin
            pick_entry(j);
            do_lookup(cam_mdl[j][key_w-1:0], '0, cam_mdl[j][cam_w-1 -: vlan_nib_w]);
        end
        for (int i = 0; i < n_miss; i++) begin
            r = rand_wide();
            do_lookup(r[key_w-1:0], '0, r[1000 +: vlan_nib_w]);
        end

        // masked key bits, then a wrong VLAN nibble
        for (int i = 0; i < n_tern; i++) begin
            pick_entry(j);
            r = rand_wide();
            m = r[key_w-1:0];
            do_lookup(cam_mdl[j][key_w-1:0] ^ (r[200 +: key_w] & m), m,
                      cam_mdl[j][cam_w-1 -: vlan_nib_w]);
            do_lookup(cam_mdl[j][key_w-1:0], m,
                      cam_mdl[j][cam_w-1 -: vlan_nib_w] ^ 4'(1 + lcg_next() % 15));
        end

        // three overlapping entries, lowest index must answer
        r = rand_wide();
        diff = key_w'(lcg_next() | 32'd1);
        new_ent[0] = r[cam_w-1:0];
        new_ent[1] = r[cam_w-1:0] ^ {{vlan_nib_w{1'b0}}, diff};
        new_ent[2] = r[cam_w-1:0];
        send_cam(8'(lcg_next()), 3);
        do_lookup(new_ent[1][key_w-1:0], diff, new_ent[1][cam_w-1 -: vlan_nib_w]);
        do_lookup(new_ent[0][key_w-1:0], '0, new_ent[0][cam_w-1 -: vlan_nib_w]);

        send_actions(8'(lcg_next()), 5);
        for (int i = 0; i < n_rehit; i++) begin
            pick_entry(j);
            do_lookup(cam_mdl[j][key_w-1:0], '0, cam_mdl[j][cam_w-1 -: vlan_nib_w]);
        end

        repeat (5) @(posedge clk);
        if (fwd_q.size() != 0) begin
            $display("%0d forwarded beats never came out", fwd_q.size());
            n_other_err++;
        end
        n_other_err += i_dut.i_chk.fail_cnt;
        $display("errors: %0d value mismatches, %0d other failures", n_val_err, n_other_err);
        if (n_val_err == 0 && n_other_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/lookup_pkg.sv
hw/ctrl_cfg_parser.sv
hw/ternary_cam.sv
hw/action_ram.sv
hw/lookup_fsm.sv
hw/lookup_engine.sv
dv/lookup_engine_chk.sv
dv/tb_lookup_engine.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the match stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_lookup_engine -f all.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "no result line in sim.log"
exit 1
